// ==== Makefile ====
# Verilator build and run of the fetch subsystem testbench

VERILATOR  ?= verilator
TOP        := fetch_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := TEST RESULT: PASS

VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR) --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
RUN_ARGS   := +verilator+error+limit+100

SOURCES    := $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/fetch_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_chk (
    input wire                   f_clk,
    input wire                   f_rst_n,
    input wire                   i_imem_req,
    input wire                   i_imem_ack,
    input wire [`FETCH_XLEN-1:0] i_imem_addr,
    input wire                   i_stall,
    input wire                   i_valid
);

    int fail_count = 0;

    // ########################################
    // Memory port
    // ########################################
    req_held: assert property (@(posedge f_clk) disable iff (!f_rst_n)
        i_imem_req && !i_imem_ack |=> i_imem_req)
        else begin
            fail_count++;
            $error("Request dropped before its acknowledge");
        end

    addr_stable: assert property (@(posedge f_clk) disable iff (!f_rst_n)
        i_imem_req && !i_imem_ack |=> $stable(i_imem_addr))
        else begin
            fail_count++;
            $error("Request address moved while waiting for acknowledge");
        end

    // ########################################
    // Output strobe
    // ########################################
    no_valid_in_stall: assert property (@(posedge f_clk) disable iff (!f_rst_n)
        i_valid |-> !i_stall)
        else begin
            fail_count++;
            $error("Valid strobe while decode is stalled");
        end

    // Quiet for the first two cycles after reset release
    quiet_first: assert property (@(posedge f_clk) $rose(f_rst_n) |-> !i_valid && !i_imem_req)
        else begin
            fail_count++;
            $error("Activity in the first cycle after reset");
        end

    quiet_second: assert property (@(posedge f_clk) $rose(f_rst_n) |=> !i_valid)
        else begin
            fail_count++;
            $error("Valid strobe in the second cycle after reset");
        end

endmodule

bind fetch_top fetch_chk i_fetch_chk (
    .f_clk       (f_clk),
    .f_rst_n     (f_rst_n),
    .i_imem_req  (o_imem_req),
    .i_imem_ack  (i_imem_ack),
    .i_imem_addr (o_imem_addr),
    .i_stall     (i_stall),
    .i_valid     (o_valid)
);

`default_nettype wire

// ==== bench/fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_tb import fetch_isa_pkg::*; ();

    localparam int RESET_CYCLES     = 4;
    localparam int SEQ_WORDS        = 50;
    localparam int REDIRECT_WORDS   = 5;
    localparam int DECODE_WORDS     = 12;
    localparam int TOTAL_WORDS      = 1 + 2 * SEQ_WORDS + 2 * REDIRECT_WORDS + DECODE_WORDS;
    localparam int STALL_RANDOM_MAX = 200;
    localparam int STALL_BUDGET     = STALL_RANDOM_MAX + 56;
    localparam int WATCHDOG_CYCLES  = TOTAL_WORDS * 8 + STALL_BUDGET + RESET_CYCLES;
    localparam int STALL_OFF        = 0;
    localparam int STALL_HIGH       = 1;
    localparam int STALL_RANDOM     = 2;
    localparam logic [`FETCH_XLEN-1:0] REDIRECT_PC_A = 32'h0000_2000;
    localparam logic [`FETCH_XLEN-1:0] REDIRECT_PC_B = 32'h0000_3404;

    logic                   f_clk;
    logic                   f_rst_n;
    logic                   i_imem_ack = 1'b0;
    logic [`FETCH_XLEN-1:0] i_imem_data = '0;
    logic                   i_stall = 1'b0;
    logic                   i_redirect;
    logic [`FETCH_XLEN-1:0] i_redirect_pc;
    logic                   o_imem_req;
    logic [`FETCH_XLEN-1:0] o_imem_addr;
    logic                   o_valid;
    logic [`FETCH_XLEN-1:0] o_instr;
    logic [`FETCH_XLEN-1:0] o_addr;
    logic [4:0]             o_rd;
    logic [4:0]             o_rs1;
    logic [4:0]             o_rs2;
    logic [`FETCH_XLEN-1:0] o_imm;
    logic                   o_is_branch;
    logic                   o_is_jump;

    int                     mem_wait = 0;      // Cycles left before the next acknowledge
    int                     stall_mode = STALL_OFF;
    int                     stall_cycles = 0;
    int                     errors = 0;
    int                     check_count = 0;
    int                     word_count = 0;
    int                     test_num = 0;
    int                     errors_before;
    logic [`FETCH_XLEN-1:0] exp_addr = `FETCH_RESET_PC;
    logic [5:0]             opcode_seen = '0;

    fetch_top i_fetch_top (.*);

    initial begin
        f_clk = 1'b0;
        forever #50 f_clk = ~f_clk;
    end

    // Word stored at each address with the opcode cycling through six classes
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] mix;
        opcode_e     op;
        mix = (addr ^ {addr[15:0], addr[31:16]}) * 32'h9e37_79b1;
        case ((addr >> 2) % 32'd6)
            32'd0:   op = OP_LOAD;
            32'd1:   op = OP_OPIMM;
            32'd2:   op = OP_OP;
            32'd3:   op = OP_BRANCH;
            32'd4:   op = OP_JALR;
            default: op = OP_JAL;
        endcase
        return {mix[31:7], op};
    endfunction

    // Packed as {is_jump, is_branch, imm, rs2, rs1, rd}
    function automatic logic [48:0] predecode_ref(input logic [31:0] w);
        logic is_branch;
        logic is_jump;
        is_branch = (w[6:0] == 7'b1100011);
        is_jump   = (w[6:0] == 7'b1101111) || (w[6:0] == 7'b1100111);
        return {is_jump, is_branch, {{20{w[31]}}, w[31:20]}, w[24:20], w[19:15], w[11:7]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_word();
        logic [31:0] exp_dec_word;
        logic [48:0] exp_dec;
        exp_dec_word = mem_word(exp_addr);
        exp_dec      = predecode_ref(exp_dec_word);
        check_value("o_addr", exp_addr, o_addr);
        check_value("o_instr", exp_dec_word, o_instr);
        check_value("o_rd", {27'd0, exp_dec[4:0]}, {27'd0, o_rd});
        check_value("o_rs1", {27'd0, exp_dec[9:5]}, {27'd0, o_rs1});
        check_value("o_rs2", {27'd0, exp_dec[14:10]}, {27'd0, o_rs2});
        check_value("o_imm", exp_dec[46:15], o_imm);
        check_value("o_is_branch", {31'd0, exp_dec[47]}, {31'd0, o_is_branch});
        check_value("o_is_jump", {31'd0, exp_dec[48]}, {31'd0, o_is_jump});
        case (opcode_e'(o_instr[6:0]))
            OP_LOAD:   opcode_seen[0] = 1'b1;
            OP_OPIMM:  opcode_seen[1] = 1'b1;
            OP_OP:     opcode_seen[2] = 1'b1;
            OP_BRANCH: opcode_seen[3] = 1'b1;
            OP_JALR:   opcode_seen[4] = 1'b1;
            OP_JAL:    opcode_seen[5] = 1'b1;
            default:   opcode_seen = opcode_seen;
        endcase
        exp_addr   = exp_addr + `FETCH_PC_STEP;
        word_count = word_count + 1;
    endtask

    // ########################################
    // Memory model and decode stall driver
    // ########################################
    initial begin
        void'($urandom(32'ha411));
        forever begin
            @(posedge f_clk);
            if (i_imem_ack) begin
                i_imem_ack <= 1'b0;
                mem_wait   <= $urandom_range(3, 0);
            end else if (f_rst_n && o_imem_req) begin
                if (mem_wait == 0) begin
                    i_imem_ack  <= 1'b1;
                    i_imem_data <= mem_word(o_imem_addr);
                end else begin
                    mem_wait <= mem_wait - 1;
                end
            end
            case (stall_mode)
                STALL_HIGH: i_stall <= 1'b1;
                STALL_RANDOM: begin
                    if (stall_cycles < STALL_RANDOM_MAX && $urandom_range(9, 0) < 6) begin
                        i_stall      <= 1'b1;
                        stall_cycles <= stall_cycles + 1;
                    end else begin
                        i_stall <= 1'b0;
                    end
                end
                default: i_stall <= 1'b0;
            endcase
        end
    end

    // The redirect target becomes the next expected address
    always @(posedge f_clk) begin
        if (f_rst_n) begin
            if (o_valid && i_stall) begin
                errors = errors + 1;
                $display("Error at %0t: a word was delivered while i_stall was high", $time);
            end
            if (i_redirect) begin
                if (o_valid) begin
                    errors = errors + 1;
                    $display("Error at %0t: a word was delivered during a redirect", $time);
                end
                exp_addr = i_redirect_pc;
            end else if (o_valid) begin
                compare_word();
            end
        end
    end

    task automatic run_words(input int n);
        int target;
        @(negedge f_clk);
        target = word_count + n;
        while (word_count < target) @(negedge f_clk);
    endtask

    task automatic pulse_redirect(input logic [31:0] pc);
        i_redirect    <= 1'b1;
        i_redirect_pc <= pc;
        @(posedge f_clk);
        i_redirect <= 1'b0;
    endtask

    task automatic report_test(input string name, input int words);
        test_num = test_num + 1;
        if (errors == errors_before) begin
            $display("Test %0d %s: ok, %0d words", test_num, name, words);
        end else begin
            $display("Test %0d %s: %0d errors, %0d words", test_num, name,
                     errors - errors_before, words);
        end
        errors_before = errors;
    endtask

    initial begin
        int total_errors;
        f_rst_n       = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        errors_before = 0;
        repeat (RESET_CYCLES) @(posedge f_clk);
        f_rst_n <= 1'b1;

        @(negedge f_clk);
        check_value("o_imem_req", 32'd0, {31'd0, o_imem_req});
        @(negedge f_clk);
        check_value("o_imem_req", 32'd1, {31'd0, o_imem_req});
        check_value("o_imem_addr", `FETCH_RESET_PC, o_imem_addr);
        run_words(1);
        report_test("reset and first fetch", 1);

        run_words(SEQ_WORDS);
        report_test("sequential run", SEQ_WORDS);

        stall_mode <= STALL_RANDOM;
        run_words(SEQ_WORDS);
        stall_mode <= STALL_OFF;
        report_test("random stalls", SEQ_WORDS);

        // Redirect while memory still owes the open request
        @(negedge f_clk);
        while (!(o_imem_req && !i_imem_ack && mem_wait > 0)) @(negedge f_clk);
        @(posedge f_clk);
        pulse_redirect(REDIRECT_PC_A);
        run_words(REDIRECT_WORDS);
        stall_mode <= STALL_HIGH;  // Fills the buffer until the FSM parks
        @(negedge f_clk);
        while (o_imem_req) @(negedge f_clk);
        @(posedge f_clk);
        pulse_redirect(REDIRECT_PC_B);
        stall_mode <= STALL_OFF;
        run_words(REDIRECT_WORDS);
        report_test("redirects", 2 * REDIRECT_WORDS);

        run_words(DECODE_WORDS);
        if (opcode_seen != 6'b111111) begin
            errors = errors + 1;
            $display("Error: not every opcode class was delivered, seen mask %b", opcode_seen);
        end
        report_test("pre-decode", DECODE_WORDS);

        total_errors = errors + i_fetch_top.i_fetch_chk.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d, words: %0d",
                 check_count, errors, i_fetch_top.i_fetch_chk.fail_count, word_count);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge f_clk);
        $display("Watchdog: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/fetch_isa_pkg.sv
logic/fetch_ctrl_pkg.sv
logic/fetch_if.sv
logic/fetch_fsm.sv
logic/pc_counter.sv
logic/fetch_buffer.sv
logic/instr_predecode.sv
logic/fetch_top.sv
bench/fetch_chk.sv
bench/fetch_tb.sv

// ==== logic/fetch_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_buffer import fetch_isa_pkg::*; (
    input  wire                    f_clk,
    input  wire                    f_rst_n,
    input  wire                    i_load,
    input  wire                    i_flush,
    input  wire [`FETCH_XLEN-1:0]  i_data,
    input  wire [`FETCH_XLEN-1:0]  i_addr,
    output logic                   o_full,
    fetch_word_if.producer         word_if
);

    instr_u                 held_word;
    logic [`FETCH_XLEN-1:0] held_addr;
    logic                   full_q;
    logic                   drain;

    // The word leaves when decode is free and no redirect kills it
    assign drain = full_q && !word_if.stall && !i_flush;

    // ######################################
    // Occupancy
    // ######################################
    always_ff @(posedge f_clk or negedge f_rst_n) begin
        if (!f_rst_n) begin
            full_q <= 1'b0;
        end else if (i_flush) begin
            full_q <= 1'b0;
        end else if (i_load) begin
            full_q <= 1'b1;  // Covers a refill in the cycle the old word drains
        end else if (drain) begin
            full_q <= 1'b0;
        end
    end

    // Word and its address are captured together
    always_ff @(posedge f_clk) begin
        if (i_load) begin
            held_word <= i_data;
            held_addr <= i_addr;
        end
    end

    assign o_full        = full_q;
    assign word_if.word  = held_word;
    assign word_if.addr  = held_addr;
    assign word_if.valid = drain;

endmodule

`default_nettype wire

// ==== logic/fetch_ctrl_pkg.sv ====
`default_nettype none

package fetch_ctrl_pkg;

    // ######################################
    // Fetch sequencer states
    // ######################################
    typedef enum logic [1:0] {
        ST_BOOT  = 2'b00,  // One idle cycle after reset
        ST_FETCH = 2'b01,  // Request is held towards memory
        ST_HOLD  = 2'b10,  // No request while decode holds a full buffer
        ST_DRAIN = 2'b11   // Old request still open after a redirect
    } fetch_state_e;

endpackage

`default_nettype wire

// ==== logic/fetch_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_fsm import fetch_ctrl_pkg::*; (
    input  wire                    f_clk,
    input  wire                    f_rst_n,
    input  wire                    i_imem_ack,
    input  wire                    i_redirect,
    input  wire [`FETCH_XLEN-1:0]  i_redirect_pc,
    input  wire                    i_buf_full,
    input  wire                    i_stall,
    output logic                   o_imem_req,
    output logic                   o_buf_load,
    output logic                   o_buf_flush,
    pc_ctrl_if.ctrl                pc_ctrl
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    logic         can_take;
    logic         in_flight;

    // Buffer is empty or hands its word to decode in this cycle
    assign can_take  = !i_buf_full || !i_stall;
    assign in_flight = (state_q == ST_FETCH) || (state_q == ST_DRAIN);
    assign o_imem_req = in_flight;

    always_comb begin
        state_d         = state_q;
        o_buf_load      = 1'b0;
        o_buf_flush     = 1'b0;
        pc_ctrl.advance = 1'b0;
        pc_ctrl.load    = 1'b0;
        pc_ctrl.load_pc = i_redirect_pc;

        if (i_redirect) begin
            o_buf_flush  = 1'b1;
            pc_ctrl.load = 1'b1;
            if (in_flight && !i_imem_ack) begin
                state_d = ST_DRAIN;  // Memory still owes a word for the old stream
            end else begin
                pc_ctrl.advance = 1'b1;
                state_d         = ST_FETCH;
            end
        end else begin
            case (state_q)
                ST_BOOT: begin
                    state_d = ST_FETCH;
                end
                ST_FETCH: begin
                    if (i_imem_ack && can_take) begin
                        o_buf_load      = 1'b1;
                        pc_ctrl.advance = 1'b1;
                    end else if (i_imem_ack) begin
                        // No room for the word, fetch it again once decode moves
                        state_d = ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (can_take) begin
                        state_d = ST_FETCH;
                    end
                end
                ST_DRAIN: begin
                    if (i_imem_ack) begin
                        pc_ctrl.advance = 1'b1;  // Data dropped, redirect target goes out next
                        state_d         = ST_FETCH;
                    end
                end
                default: state_d = ST_BOOT;
            endcase
        end
    end

    always_ff @(posedge f_clk or negedge f_rst_n) begin
        if (!f_rst_n) begin
            state_q <= ST_BOOT;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

// ######################################
// Held word from the buffer to pre-decode
// ######################################
interface fetch_word_if import fetch_isa_pkg::*; ();
    instr_u                 word;
    logic [`FETCH_XLEN-1:0] addr;
    logic                   valid;  // Single cycle per delivered word
    logic                   stall;

    modport producer (
        output word,
        output addr,
        output valid,
        input  stall
    );

    modport consumer (
        input word,
        input addr,
        input valid
    );
endinterface

// ######################################
// PC controls from the FSM to the counter
// ######################################
interface pc_ctrl_if ();
    logic                   advance;
    logic                   load;     // Wins over advance
    logic [`FETCH_XLEN-1:0] load_pc;
    logic [`FETCH_XLEN-1:0] pc;       // Address currently requested

    modport ctrl (output advance, output load, output load_pc);
    modport counter (input advance, input load, input load_pc, output pc);
endinterface

`default_nettype wire

// ==== logic/fetch_isa_pkg.sv ====
`default_nettype none

package fetch_isa_pkg;

    // Major opcodes that the front end needs to recognise
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_OPIMM  = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0] imm12;  // Sits on the funct7 and rs2 bits of the R view
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } itype_t;

    // One fetched word seen as either format
    typedef union packed {
        rtype_t rtype;
        itype_t itype;
    } instr_u;

endpackage

`default_nettype wire

// ==== logic/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ######################################
// Fetch subsystem sizing
// ######################################

// Width of an instruction word, an address and the PC
`define FETCH_XLEN 32

// First address fetched after reset
`define FETCH_RESET_PC 32'h0000_1000

// Distance between two sequential instructions
`define FETCH_PC_STEP 32'd4

`endif

// ==== logic/fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module fetch_top (
    input  wire                    f_clk,
    input  wire                    f_rst_n,
    input  wire                    i_imem_ack,
    input  wire [`FETCH_XLEN-1:0]  i_imem_data,
    input  wire                    i_stall,
    input  wire                    i_redirect,
    input  wire [`FETCH_XLEN-1:0]  i_redirect_pc,
    output logic                   o_imem_req,
    output logic [`FETCH_XLEN-1:0] o_imem_addr,
    output logic                   o_valid,
    output logic [`FETCH_XLEN-1:0] o_instr,
    output logic [`FETCH_XLEN-1:0] o_addr,
    output logic [4:0]             o_rd,
    output logic [4:0]             o_rs1,
    output logic [4:0]             o_rs2,
    output logic [`FETCH_XLEN-1:0] o_imm,
    output logic                   o_is_branch,
    output logic                   o_is_jump
);

    logic buf_load;
    logic buf_flush;
    logic buf_full;

    fetch_word_if i_word_if ();
    pc_ctrl_if    i_pc_if ();

    assign i_word_if.stall = i_stall;  // Decode back-pressure reaches the buffer here

    fetch_fsm i_fetch_fsm (
        .f_clk         (f_clk),
        .f_rst_n       (f_rst_n),
        .i_imem_ack    (i_imem_ack),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_buf_full    (buf_full),
        .i_stall       (i_stall),
        .o_imem_req    (o_imem_req),
        .o_buf_load    (buf_load),
        .o_buf_flush   (buf_flush),
        .pc_ctrl       (i_pc_if.ctrl)
    );

    pc_counter i_pc_counter (
        .f_clk      (f_clk),
        .f_rst_n    (f_rst_n),
        .pc_ctrl    (i_pc_if.counter),
        .o_req_addr (o_imem_addr)
    );

    // Each word is tagged with the address of the request that fetched it
    fetch_buffer i_fetch_buffer (
        .f_clk   (f_clk),
        .f_rst_n (f_rst_n),
        .i_load  (buf_load),
        .i_flush (buf_flush),
        .i_data  (i_imem_data),
        .i_addr  (i_pc_if.pc),
        .o_full  (buf_full),
        .word_if (i_word_if.producer)
    );

    instr_predecode i_instr_predecode (
        .word_if     (i_word_if.consumer),
        .o_valid     (o_valid),
        .o_instr     (o_instr),
        .o_addr      (o_addr),
        .o_rd        (o_rd),
        .o_rs1       (o_rs1),
        .o_rs2       (o_rs2),
        .o_imm       (o_imm),
        .o_is_branch (o_is_branch),
        .o_is_jump   (o_is_jump)
    );

endmodule

`default_nettype wire

// ==== logic/instr_predecode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module instr_predecode import fetch_isa_pkg::*; (
    fetch_word_if.consumer         word_if,
    output logic                   o_valid,
    output logic [`FETCH_XLEN-1:0] o_instr,
    output logic [`FETCH_XLEN-1:0] o_addr,
    output logic [4:0]             o_rd,
    output logic [4:0]             o_rs1,
    output logic [4:0]             o_rs2,
    output logic [`FETCH_XLEN-1:0] o_imm,
    output logic                   o_is_branch,
    output logic                   o_is_jump
);

    instr_u  word;
    opcode_e opcode;

    assign word   = word_if.word;
    assign opcode = word.rtype.opcode;

    assign o_valid = word_if.valid;
    assign o_instr = word;
    assign o_addr  = word_if.addr;

    // Register fields sit at the same place in every format
    assign o_rd  = word.rtype.rd;
    assign o_rs1 = word.rtype.rs1;
    assign o_rs2 = word.rtype.rs2;

    assign o_imm = {{(`FETCH_XLEN - 12){word.itype.imm12[11]}}, word.itype.imm12};

    // ######################################
    // Control flow class
    // ######################################
    always_comb begin
        o_is_branch = 1'b0;
        o_is_jump   = 1'b0;
        case (opcode)
            OP_BRANCH: o_is_branch = 1'b1;
            OP_JAL,
            OP_JALR:   o_is_jump   = 1'b1;  // Both link and leave the sequence
            default:   o_is_branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/pc_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_params.svh"

module pc_counter (
    input  wire                    f_clk,
    input  wire                    f_rst_n,
    pc_ctrl_if.counter             pc_ctrl,
    output logic [`FETCH_XLEN-1:0] o_req_addr
);

    logic [`FETCH_XLEN-1:0] req_addr;  // Address of the request in flight
    logic [`FETCH_XLEN-1:0] next_pc;   // Address that the following request will use
    logic [`FETCH_XLEN-1:0] base;

    // A load replaces the sequential address before any step is taken
    assign base = pc_ctrl.load ? pc_ctrl.load_pc : next_pc;

    always_ff @(posedge f_clk or negedge f_rst_n) begin
        if (!f_rst_n) begin
            req_addr <= `FETCH_RESET_PC;
            next_pc  <= `FETCH_RESET_PC + `FETCH_PC_STEP;
        end else if (pc_ctrl.advance) begin
            req_addr <= base;  // A new request starts with this address
            next_pc  <= base + `FETCH_PC_STEP;
        end else if (pc_ctrl.load) begin
            // The open request keeps its address until memory answers it
            next_pc <= pc_ctrl.load_pc;
        end
    end

    assign pc_ctrl.pc = req_addr;
    assign o_req_addr = req_addr;

endmodule

`default_nettype wire
